/* secv_defines.svh */
// Width and sizing macros: XLEN and default issue queue depth
`ifndef SECV_DEFINES_SVH
`define SECV_DEFINES_SVH

// Data and address width of the core
// Sets xlen_t and imm_t in both packages
`define SECV_XLEN 32

// Default number of issue queue entries
// Any depth of 1 or more works, power of two not required
`define SECV_BQ_DEPTH 4

`endif

/* secv_isa_pkg.sv */
// RV32I instruction field types, opcode/funct3 constants, immediate type and sign-extension helpers
`include "secv_defines.svh"

package secv_isa_pkg;

    // Raw instruction word, always 32 bit in RV32I
    typedef logic [31:0]             inst_t;
    typedef logic [6:0]              opcode_t;   // Major opcode, inst[6:0]
    typedef logic [2:0]              funct3_t;   // Minor code, inst[14:12]
    typedef logic [`SECV_XLEN-1:0]   imm_t;      // Sign-extended immediate

    // Major opcodes handled by the branch unit
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;  // Bxx
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;

    // Branch conditions, 3'b010 and 3'b011 unused
    localparam funct3_t FUNCT3_BRANCH_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BRANCH_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BRANCH_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BRANCH_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BRANCH_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BRANCH_BGEU = 3'b111;
    localparam funct3_t FUNCT3_JALR        = 3'b000;  // Only legal JALR code

    // I-type, 12 bit from inst[31:20]
    function automatic imm_t sext_imm_i(input inst_t inst);
        logic [11:0] raw;
        raw = inst[31:20];
        return imm_t'($signed(raw));
    endfunction

    // B-type, 13 bit with implicit zero LSB
    function automatic imm_t sext_imm_b(input inst_t inst);
        logic [12:0] raw;
        raw = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        return imm_t'($signed(raw));
    endfunction

    // J-type, 21 bit with implicit zero LSB
    function automatic imm_t sext_imm_j(input inst_t inst);
        logic [20:0] raw;
        raw = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return imm_t'($signed(raw));
    endfunction

endpackage

/* secv_branch_pkg.sv */
// Branch operation enum and data word type of the branch datapath
`include "secv_defines.svh"

package secv_branch_pkg;

    // PC, rs1, rs2, target and link values
    typedef logic [`SECV_XLEN-1:0] xlen_t;

    // Decoded operation, assigned by the decoder only
    // Conditional branches first, then jumps
    typedef enum logic [3:0] {
        BR_BEQ,      // rs1 == rs2
        BR_BNE,      // rs1 != rs2
        BR_BLT,      // Signed less than
        BR_BGE,      // Signed greater or equal
        BR_BLTU,     // Unsigned less than
        BR_BGEU,     // Unsigned greater or equal
        BR_JAL,      // pc + J-imm, link pc+4
        BR_JALR,     // rs1 + I-imm, link pc+4
        BR_ILLEGAL   // Raises err, no write-backs
    } br_op_e;

endpackage

/* branch_op_if.sv */
// Interface for one decoded branch operation with valid/ready and producer/consumer modports
`timescale 1ns/1ns

interface branch_op_if
    import secv_isa_pkg::*;
    import secv_branch_pkg::*;
();

    logic   valid;   // Record present
    logic   ready;   // Sink can take it
    br_op_e op;      // Decoded operation
    xlen_t  pc;      // PC of the instruction
    xlen_t  rs1;     // Source register 1 value
    xlen_t  rs2;     // Source register 2 value
    imm_t   imm;     // Sign-extended I/B/J immediate

    // Sender holds valid and data until valid && ready
    modport producer (
        output valid, op, pc, rs1, rs2, imm,
        input  ready
    );

    modport consumer (
        input  valid, op, pc, rs1, rs2, imm,
        output ready
    );

endinterface

/* branch_decode.sv */
// Registered instruction decoder: classifies branch/jump/illegal and builds the immediate
`timescale 1ns/1ns

module branch_decode
    import secv_isa_pkg::*;
    import secv_branch_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,

    // Request side
    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  inst_t            req_inst_i,    // Raw instruction
    input  xlen_t            req_pc_i,      // Its PC
    input  xlen_t            req_rs1_i,     // rs1 operand
    input  xlen_t            req_rs2_i,     // rs2 operand

    // Decoded record towards the queue
    branch_op_if.producer    op_o
);

    opcode_t opcode;
    funct3_t funct3;
    br_op_e  dec_op;     // Operation of the incoming request
    imm_t    dec_imm;    // Its sign-extended immediate
    logic    req_fire;

    assign opcode = req_inst_i[6:0];
    assign funct3 = req_inst_i[14:12];

    // Output stage free, or drained this cycle
    assign req_ready_o = !op_o.valid || op_o.ready;
    assign req_fire    = req_valid_i && req_ready_o;

    always_comb begin
        dec_op  = BR_ILLEGAL;  // Unknown opcode
        dec_imm = '0;
        case (opcode)
            OPCODE_BRANCH: begin
                dec_imm = sext_imm_b(req_inst_i);
                case (funct3)
                    FUNCT3_BRANCH_BEQ:  dec_op = BR_BEQ;
                    FUNCT3_BRANCH_BNE:  dec_op = BR_BNE;
                    FUNCT3_BRANCH_BLT:  dec_op = BR_BLT;
                    FUNCT3_BRANCH_BGE:  dec_op = BR_BGE;
                    FUNCT3_BRANCH_BLTU: dec_op = BR_BLTU;
                    FUNCT3_BRANCH_BGEU: dec_op = BR_BGEU;
                    default: begin
                        dec_op  = BR_ILLEGAL;  // funct3 2 and 3
                        dec_imm = '0;
                    end
                endcase
            end
            OPCODE_JAL: begin
                dec_op  = BR_JAL;
                dec_imm = sext_imm_j(req_inst_i);
            end
            OPCODE_JALR: begin
                if (funct3 == FUNCT3_JALR) begin
                    dec_op  = BR_JALR;
                    dec_imm = sext_imm_i(req_inst_i);
                end
            end
            default: ;
        endcase
    end

    // One-entry output register, valid flag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            op_o.valid <= 1'b0;
        end else if (req_fire) begin
            op_o.valid <= 1'b1;  // Refilled, possibly same cycle as drain
        end else if (op_o.ready) begin
            op_o.valid <= 1'b0;
        end
    end

    // Record payload
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            op_o.op  <= dec_op;
            op_o.pc  <= req_pc_i;
            op_o.rs1 <= req_rs1_i;
            op_o.rs2 <= req_rs2_i;
            op_o.imm <= dec_imm;
        end
    end

endmodule

/* branch_queue.sv */
// Issue queue: circular-buffer FIFO of decoded branch operations
`timescale 1ns/1ns
`include "secv_defines.svh"

module branch_queue
    import secv_isa_pkg::*;
    import secv_branch_pkg::*;
#(
    parameter int DEPTH = `SECV_BQ_DEPTH
) (
    input  logic             clk_i,
    input  logic             reset_i,
    branch_op_if.consumer    push_i,   // From the decoder
    branch_op_if.producer    pop_o     // To the branch unit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Entry storage
    br_op_e op_mem  [DEPTH];
    xlen_t  pc_mem  [DEPTH];
    xlen_t  rs1_mem [DEPTH];
    xlen_t  rs2_mem [DEPTH];
    imm_t   imm_mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;   // Occupied entries
    logic full;
    logic push_fire;
    logic pop_fire;

    assign full      = (count == cnt_t'(DEPTH));
    assign push_fire = push_i.valid && push_i.ready;
    assign pop_fire  = pop_o.valid && pop_o.ready;

    // Full queue still takes a push when the head leaves
    assign push_i.ready = !full || pop_o.ready;

    // Head record
    assign pop_o.valid = (count != '0);
    assign pop_o.op    = op_mem[rd_ptr];
    assign pop_o.pc    = pc_mem[rd_ptr];
    assign pop_o.rs1   = rs1_mem[rd_ptr];
    assign pop_o.rs2   = rs2_mem[rd_ptr];
    assign pop_o.imm   = imm_mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither, unchanged
            endcase
        end
    end

    // Write at tail
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            op_mem[wr_ptr]  <= push_i.op;
            pc_mem[wr_ptr]  <= push_i.pc;
            rs1_mem[wr_ptr] <= push_i.rs1;
            rs2_mem[wr_ptr] <= push_i.rs2;
            imm_mem[wr_ptr] <= push_i.imm;
        end
    end

endmodule

/* branch.sv */
// Branch function unit: target, condition and link computation with registered result stage
`timescale 1ns/1ns

module branch
    import secv_branch_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,

    branch_op_if.consumer    op_i,          // Head of the issue queue

    // Result port
    output logic             res_valid_o,
    input  logic             res_ready_i,
    output xlen_t            res_pc_o,      // Next PC target
    output logic             res_pc_wb_o,   // Take the target
    output xlen_t            res_rd_o,      // Link value
    output logic             res_rd_wb_o,   // Write link to rd
    output logic             res_err_o      // Illegal instruction
);

    xlen_t pc_ret;   // pc + 4
    xlen_t pc_rel;   // pc + imm, Bxx and JAL
    xlen_t pc_abs;   // rs1 + imm, JALR
    xlen_t nxt_pc;
    xlen_t nxt_rd;
    logic  nxt_pc_wb;
    logic  nxt_rd_wb;
    logic  nxt_err;
    logic  op_fire;

    // Result register free, or read out this cycle
    assign op_i.ready = !res_valid_o || res_ready_i;
    assign op_fire    = op_i.valid && op_i.ready;

    assign pc_ret = op_i.pc + xlen_t'(4);
    assign pc_rel = op_i.pc + op_i.imm;
    assign pc_abs = op_i.rs1 + op_i.imm;  // Bit 0 kept as is

    always_comb begin
        nxt_pc    = '0;
        nxt_rd    = '0;
        nxt_pc_wb = 1'b0;
        nxt_rd_wb = 1'b0;
        nxt_err   = 1'b0;
        case (op_i.op)
            BR_BEQ: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = (op_i.rs1 == op_i.rs2);
            end
            BR_BNE: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = (op_i.rs1 != op_i.rs2);
            end
            BR_BLT: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = ($signed(op_i.rs1) < $signed(op_i.rs2));
            end
            BR_BGE: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = ($signed(op_i.rs1) >= $signed(op_i.rs2));
            end
            BR_BLTU: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = (op_i.rs1 < op_i.rs2);
            end
            BR_BGEU: begin
                nxt_pc    = pc_rel;
                nxt_pc_wb = (op_i.rs1 >= op_i.rs2);
            end
            BR_JAL, BR_JALR: begin
                nxt_pc    = (op_i.op == BR_JAL) ? pc_rel : pc_abs;
                nxt_rd    = pc_ret;  // Link address
                nxt_pc_wb = 1'b1;
                nxt_rd_wb = 1'b1;
            end
            default: nxt_err = 1'b1;  // BR_ILLEGAL, all else zero
        endcase
    end

    // Result valid flag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
        end else if (op_fire) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;  // Consumed, nothing new
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (op_fire) begin
            res_pc_o    <= nxt_pc;
            res_pc_wb_o <= nxt_pc_wb;
            res_rd_o    <= nxt_rd;
            res_rd_wb_o <= nxt_rd_wb;
            res_err_o   <= nxt_err;
        end
    end

endmodule

/* branch_subsys.sv */
// Branch subsystem top: decoder, issue queue and branch unit with plain request/result ports
`timescale 1ns/1ns
`include "secv_defines.svh"

module branch_subsys
    import secv_isa_pkg::*;
    import secv_branch_pkg::*;
#(
    parameter int BQ_DEPTH = `SECV_BQ_DEPTH   // Issue queue entries
) (
    input  logic    clk_i,
    input  logic    reset_i,

    // Requests
    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  inst_t   req_inst_i,
    input  xlen_t   req_pc_i,
    input  xlen_t   req_rs1_i,
    input  xlen_t   req_rs2_i,

    // Results, in request order
    output logic    res_valid_o,
    input  logic    res_ready_i,
    output xlen_t   res_pc_o,
    output logic    res_pc_wb_o,
    output xlen_t   res_rd_o,
    output logic    res_rd_wb_o,
    output logic    res_err_o
);

    branch_op_if dec_q_if ();   // Decoder to queue
    branch_op_if q_bu_if ();    // Queue to branch unit

    branch_decode i_branch_decode (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_inst_i  (req_inst_i),
        .req_pc_i    (req_pc_i),
        .req_rs1_i   (req_rs1_i),
        .req_rs2_i   (req_rs2_i),
        .op_o        (dec_q_if.producer)
    );

    branch_queue #(
        .DEPTH (BQ_DEPTH)
    ) i_branch_queue (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (dec_q_if.consumer),
        .pop_o   (q_bu_if.producer)
    );

    branch i_branch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .op_i        (q_bu_if.consumer),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_pc_o    (res_pc_o),
        .res_pc_wb_o (res_pc_wb_o),
        .res_rd_o    (res_rd_o),
        .res_rd_wb_o (res_rd_wb_o),
        .res_err_o   (res_err_o)
    );

endmodule

/* tb_branch_subsys.sv */
// Testbench for branch_subsys with reference model, scoreboard, assertions, stimulus and watchdog
`timescale 1ns/1ns
`include "secv_defines.svh"

module tb_branch_subsys
    import secv_isa_pkg::*;
    import secv_branch_pkg::*;
();

    localparam int BQ_DEPTH        = `SECV_BQ_DEPTH;
    localparam int CAPACITY        = BQ_DEPTH + 2;            // Decode reg, queue, result reg
    localparam int N_REQ           = 6 * 11 + 24 + 12 + 90;   // Requests over all phases
    localparam int WATCHDOG_CYCLES = N_REQ * 20 + 200;
    localparam int DRAIN_CYCLES    = 4 * CAPACITY + 10;       // Full pipeline with ready high

    // Legal branch conditions
    localparam funct3_t BR_F3 [6] = '{FUNCT3_BRANCH_BEQ, FUNCT3_BRANCH_BNE, FUNCT3_BRANCH_BLT,
                                      FUNCT3_BRANCH_BGE, FUNCT3_BRANCH_BLTU, FUNCT3_BRANCH_BGEU};

    // Expected result of one request
    typedef struct packed {
        xlen_t pc;
        logic  pc_wb;
        xlen_t rd;
        logic  rd_wb;
        logic  err;
    } res_t;

    logic  clk_i;
    logic  reset_i;
    logic  req_valid_i;
    logic  req_ready_o;
    inst_t req_inst_i;
    xlen_t req_pc_i;
    xlen_t req_rs1_i;
    xlen_t req_rs2_i;
    logic  res_valid_o;
    logic  res_ready_i;
    xlen_t res_pc_o;
    logic  res_pc_wb_o;
    xlen_t res_rd_o;
    logic  res_rd_wb_o;
    logic  res_err_o;
    logic  res_xfer;

    res_t        exp_q [$];          // Scoreboard with oldest first
    res_t        pend_exp = '0;      // Expectation of the request on the port
    res_t        head     = '0;      // Copy of exp_q[0] for the assertions
    logic        sb_empty = 1'b1;
    int          outstanding = 0;    // Accepted but not yet delivered
    int unsigned n_sent      = 0;
    int unsigned n_results   = 0;
    int unsigned bp_mode     = 0;    // 0 always ready, 1 random, 2 long stalls

    branch_subsys #(
        .BQ_DEPTH (BQ_DEPTH)
    ) i_branch_subsys (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_inst_i  (req_inst_i),
        .req_pc_i    (req_pc_i),
        .req_rs1_i   (req_rs1_i),
        .req_rs2_i   (req_rs2_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_pc_o    (res_pc_o),
        .res_pc_wb_o (res_pc_wb_o),
        .res_rd_o    (res_rd_o),
        .res_rd_wb_o (res_rd_wb_o),
        .res_err_o   (res_err_o)
    );

    assign res_xfer = res_valid_o && res_ready_i;

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;   // 20 ns period
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // Scoreboard bookkeeping pops before it pushes
    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_q.delete();
            outstanding = 0;
        end else begin
            if (res_xfer) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                outstanding--;
                n_results++;
            end
            if (req_valid_i && req_ready_o) begin
                exp_q.push_back(pend_exp);
                outstanding++;
            end
        end
        head     = (exp_q.size() != 0) ? exp_q[0] : '0;
        sb_empty = (exp_q.size() == 0);
    end

    // Every result against the oldest expectation
    a_res_expected: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> !sb_empty)
        else report_error("Result delivered with no request outstanding");
    a_res_pc: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> res_pc_o == head.pc)
        else report_mismatch("res_pc_o differs from the reference next PC");
    a_res_pc_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> res_pc_wb_o == head.pc_wb)
        else report_mismatch("res_pc_wb_o differs from the reference taken flag");
    a_res_rd: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> res_rd_o == head.rd)
        else report_mismatch("res_rd_o differs from the reference link value");
    a_res_rd_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> res_rd_wb_o == head.rd_wb)
        else report_mismatch("res_rd_wb_o differs from the reference link flag");
    a_res_err: assert property (@(posedge clk_i) disable iff (reset_i)
        res_xfer |-> res_err_o == head.err)
        else report_mismatch("res_err_o differs from the reference error flag");

    // Reset behaviour
    a_reset_quiet: assert property (@(posedge clk_i) $past(reset_i) |-> !res_valid_o)
        else report_mismatch("res_valid_o high during or right after reset");
    a_ready_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> req_ready_o)
        else report_mismatch("req_ready_o low in the first cycle after reset");

    // Ready only drops when all stages hold a record and the result is stalled
    a_ready_fill: assert property (@(posedge clk_i) disable iff (reset_i)
        req_ready_o == (outstanding < CAPACITY || res_ready_i))
        else report_mismatch("req_ready_o does not follow the outstanding count");
    a_no_overfill: assert property (@(posedge clk_i) disable iff (reset_i)
        outstanding <= CAPACITY)
        else report_error("More requests accepted than the pipeline can hold");

    function automatic xlen_t rand_pc();
        xlen_t r;
        r = $urandom();
        return {r[31:2], 2'b00};   // Word aligned
    endfunction

    // Starts and returns on a falling edge
    task automatic send_req(input inst_t inst, input xlen_t pc, input xlen_t rs1,
                            input xlen_t rs2, input res_t exp);
        req_inst_i  = inst;
        req_pc_i    = pc;
        req_rs1_i   = rs1;
        req_rs2_i   = rs2;
        pend_exp    = exp;
        req_valid_i = 1'b1;
        @(posedge clk_i);
        while (!req_ready_o) begin
            @(posedge clk_i);
        end
        n_sent++;
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    // Random B-immediate with the taken flag from the comparison rules
    task automatic cond_branch(input funct3_t f3, input xlen_t rs1, input xlen_t rs2);
        logic [12:0] imm;
        xlen_t       pc;
        inst_t       inst;
        logic        slt;
        logic        ult;
        logic        taken;
        imm  = 13'($urandom()) & 13'h1ffe;
        pc   = rand_pc();
        inst = {imm[12], imm[10:5], 5'($urandom()), 5'($urandom()), f3, imm[4:1], imm[11],
                OPCODE_BRANCH};
        slt  = (rs1 ^ 32'h8000_0000) < (rs2 ^ 32'h8000_0000);   // Signed via MSB flip
        ult  = rs1 < rs2;
        case (f3)
            FUNCT3_BRANCH_BEQ:  taken = (rs1 == rs2);
            FUNCT3_BRANCH_BNE:  taken = (rs1 != rs2);
            FUNCT3_BRANCH_BLT:  taken = slt;
            FUNCT3_BRANCH_BGE:  taken = !slt;
            FUNCT3_BRANCH_BLTU: taken = ult;
            default:            taken = !ult;
        endcase
        send_req(inst, pc, rs1, rs2,
                 '{pc: pc + {{19{imm[12]}}, imm}, pc_wb: taken, rd: '0, rd_wb: 1'b0, err: 1'b0});
    endtask

    task automatic branch_corners(input funct3_t f3);
        int unsigned n;
        xlen_t       a;
        a = $urandom();
        cond_branch(f3, a, a);                           // Equal
        cond_branch(f3, 32'h7fff_ffff, 32'h8000_0000);   // Signed boundary
        cond_branch(f3, 32'h8000_0000, 32'h7fff_ffff);
        cond_branch(f3, 32'hffff_ffff, 32'h0000_0000);   // Unsigned boundary
        cond_branch(f3, 32'h0000_0000, 32'hffff_ffff);
        for (n = 0; n < 6; n++) begin
            cond_branch(f3, $urandom(), $urandom());
        end
    endtask

    task automatic jal_jump();
        logic [20:0] imm;
        xlen_t       pc;
        inst_t       inst;
        imm  = 21'($urandom()) & 21'h1f_fffe;
        pc   = rand_pc();
        inst = {imm[20], imm[10:1], imm[11], imm[19:12], 5'($urandom()), OPCODE_JAL};
        send_req(inst, pc, $urandom(), $urandom(),
                 '{pc: pc + {{11{imm[20]}}, imm}, pc_wb: 1'b1, rd: pc + 32'd4, rd_wb: 1'b1,
                   err: 1'b0});
    endtask

    // Target keeps bit 0 of rs1 + imm
    task automatic jalr_jump();
        logic [11:0] imm;
        xlen_t       pc;
        xlen_t       rs1;
        inst_t       inst;
        imm  = 12'($urandom());
        pc   = rand_pc();
        rs1  = $urandom();
        inst = {imm, 5'($urandom()), FUNCT3_JALR, 5'($urandom()), OPCODE_JALR};
        send_req(inst, pc, rs1, $urandom(),
                 '{pc: rs1 + {{20{imm[11]}}, imm}, pc_wb: 1'b1, rd: pc + 32'd4, rd_wb: 1'b1,
                   err: 1'b0});
    endtask

    // Kind 0 foreign opcode, 1 branch funct3 2/3, 2 JALR with nonzero funct3
    task automatic bad_encoding(input int unsigned kind);
        inst_t   inst;
        opcode_t opc;
        inst = $urandom();
        case (kind)
            0: begin
                do begin
                    opc = 7'($urandom());
                end while (opc == OPCODE_BRANCH || opc == OPCODE_JAL || opc == OPCODE_JALR);
                inst[6:0] = opc;
            end
            1: begin
                inst[6:0]   = OPCODE_BRANCH;
                inst[14:12] = {2'b01, 1'($urandom())};
            end
            default: begin
                inst[6:0]   = OPCODE_JALR;
                inst[14:12] = 3'($urandom_range(1, 7));
            end
        endcase
        send_req(inst, rand_pc(), $urandom(), $urandom(), '{'0, 1'b0, '0, 1'b0, 1'b1});
    endtask

    task automatic send_random();
        xlen_t a;
        a = $urandom();
        case ($urandom_range(0, 3))
            0: cond_branch(BR_F3[$urandom_range(0, 5)], a,
                           ($urandom_range(0, 3) == 0) ? a : $urandom());
            1: jal_jump();
            2: jalr_jump();
            default: bad_encoding($urandom_range(0, 2));
        endcase
    endtask

    // Result-side ready pattern
    task automatic drive_res_ready();
        forever begin
            @(negedge clk_i);
            case (bp_mode)
                0: res_ready_i = 1'b1;
                1: res_ready_i = 1'($urandom());
                default: begin
                    res_ready_i = 1'b0;                       // Long stall fills the queue
                    repeat ($urandom_range(10, 30)) @(negedge clk_i);
                    res_ready_i = 1'b1;
                    repeat ($urandom_range(0, 3)) @(negedge clk_i);
                end
            endcase
        end
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        report_error("Timeout, results stopped arriving");
    end

    initial begin : main
        int unsigned i;
        int unsigned drain;
        void'($urandom(5));
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_inst_i  = '0;
        req_pc_i    = '0;
        req_rs1_i   = '0;
        req_rs2_i   = '0;
        res_ready_i = 1'b0;
        fork
            drive_res_ready();               // Inherits the seeded stream
        join_none
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        for (i = 0; i < 6; i++) begin      // Conditional branches
            branch_corners(BR_F3[i]);
        end
        for (i = 0; i < 12; i++) begin     // Jumps
            jal_jump();
            jalr_jump();
        end
        for (i = 0; i < 12; i++) begin     // Illegal encodings
            bad_encoding(i % 3);
        end

        bp_mode = 2;                       // Back-pressure
        for (i = 0; i < 50; i++) begin
            send_random();
        end
        bp_mode = 1;
        for (i = 0; i < 40; i++) begin
            send_random();
        end
        bp_mode = 0;

        drain = 0;
        while (outstanding != 0 && drain < DRAIN_CYCLES) begin   // Drain
            @(negedge clk_i);
            drain++;
        end
        repeat (2) @(negedge clk_i);
        if (exp_q.size() == 0 && n_results == n_sent) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Sent %0d requests but got %0d results", n_sent, n_results);
            abort_run();
        end
    end

endmodule

/* flist.f */
+incdir+.
secv_isa_pkg.sv
secv_branch_pkg.sv
branch_op_if.sv
branch_decode.sv
branch_queue.sv
branch.sv
branch_subsys.sv
tb_branch_subsys.sv

/* Bender.yml */
package:
  name: secv_branch

sources:
  - include_dirs:
      - .
    files:
      - secv_isa_pkg.sv
      - secv_branch_pkg.sv
      - branch_op_if.sv
      - branch_decode.sv
      - branch_queue.sv
      - branch.sv
      - branch_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_branch_subsys.sv
